/* cart_pkg.sv */
// Shared widths, header offsets, mapping codes and mode codes for the cartridge loader and its testbench
`default_nettype none

package cart_pkg;

	// ====================================================================
	// Loader stream
	// ====================================================================
	localparam int IOCTL_ADDR_BITS = 25;

	typedef logic [IOCTL_ADDR_BITS-1:0] ioctl_addr_t;
	typedef logic [15:0]                word_t;
	typedef logic [7:0]                 byte_t;

	// Index reserved for cheat records
	localparam logic [7:0] CODE_INDEX = 8'hFF;

	// ====================================================================
	// ROM header
	// ====================================================================
	typedef logic [23:0] mask_t;
	typedef logic [3:0]  size_code_t;
	typedef logic [2:0]  header_mode_t;
	typedef logic [1:0]  region_sel_t;
	typedef logic [7:0]  rom_type_t;

	// Copier block sits in front of the internal header
	localparam ioctl_addr_t COPIER_OFFSET = 25'h200;

	// Size byte pair location per layout
	localparam ioctl_addr_t LOROM_HDR   = 25'h7FD6;
	localparam ioctl_addr_t HIROM_HDR   = 25'hFFD6;
	localparam ioctl_addr_t EXHIROM_HDR = 25'h40FFD6;

	localparam size_code_t DEF_ROM_SIZE = 4'hC;
	localparam mask_t      MASK_UNIT    = 24'd1024;

	localparam header_mode_t HDR_AUTO    = 3'd0;
	localparam header_mode_t HDR_NONE    = 3'd1;
	localparam header_mode_t HDR_LOROM   = 3'd2;
	localparam header_mode_t HDR_HIROM   = 3'd3;
	localparam header_mode_t HDR_EXHIROM = 3'd4;

	localparam region_sel_t REGION_AUTO = 2'd0;
	localparam region_sel_t REGION_NTSC = 2'd1;
	localparam region_sel_t REGION_PAL  = 2'd2;

	localparam rom_type_t MAP_LOROM   = 8'd0;
	localparam rom_type_t MAP_HIROM   = 8'd1;
	localparam rom_type_t MAP_EXHIROM = 8'd2;

	// ====================================================================
	// Cheat record and save RAM
	// ====================================================================
	// Fields from high to low, 32 bits each
	typedef struct packed {
		logic [31:0] flags;
		logic [31:0] addr;
		logic [31:0] compare;
		logic [31:0] replace;
	} cheat_code_t;

	localparam int BSRAM_BITS      = 13;
	localparam int SD_BUFF_BITS    = 8;
	localparam int BLOCK_BYTE_BITS = SD_BUFF_BITS + 1;
	localparam int BSRAM_WORD_BITS = BSRAM_BITS - 1;
	// Block number bits that select a 512-byte block within the RAM
	localparam int BLOCK_SEL_BITS  = BSRAM_WORD_BITS - SD_BUFF_BITS;

	typedef logic [31:0] sd_lba_t;

endpackage

`default_nettype wire

/* header_detect.sv */
// Header detection on the cartridge download stream; yields mapping type, size masks and region
`timescale 1ns/1ns
`default_nettype none

module header_detect
	import cart_pkg::*;
(
	input  logic         clk_sys,
	input  logic         reset,
	input  logic         cart_download,
	input  ioctl_addr_t  ioctl_addr,
	input  word_t        ioctl_dout,
	input  logic         ioctl_wr,
	input  header_mode_t header_mode,
	input  region_sel_t  region_sel,
	output rom_type_t    rom_type,
	output mask_t        rom_mask,
	output mask_t        ram_mask,
	output logic         pal
);

	size_code_t  rom_size;
	size_code_t  ram_size;
	logic        rom_region;
	ioctl_addr_t hdr_base;
	ioctl_addr_t rom_size_addr;
	ioctl_addr_t ram_size_addr;
	logic        hdr_forced;

	// Header location for the forced layouts
	always_comb begin
		case (header_mode)
			HDR_LOROM:   hdr_base = LOROM_HDR;
			HDR_HIROM:   hdr_base = HIROM_HDR;
			HDR_EXHIROM: hdr_base = EXHIROM_HDR;
			default:     hdr_base = '0;
		endcase
	end

	assign hdr_forced    = header_mode inside {HDR_LOROM, HDR_HIROM, HDR_EXHIROM};
	assign rom_size_addr = hdr_base + COPIER_OFFSET;
	assign ram_size_addr = rom_size_addr + ioctl_addr_t'(2);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom_size   <= DEF_ROM_SIZE;
			ram_size   <= '0;
			rom_region <= 1'b0;
			rom_type   <= MAP_LOROM;
			pal        <= 1'b0;
		end else if (cart_download) begin
			if (ioctl_wr) begin
				if (ioctl_addr == '0) begin
					rom_size <= DEF_ROM_SIZE;
					ram_size <= '0;
					// Packed size byte at the very start of the image
					if (header_mode == HDR_AUTO && ioctl_dout[7:0] != 8'h00) begin
						ram_size <= ioctl_dout[7:4];
						rom_size <= ioctl_dout[3:0];
					end
					case (header_mode)
						HDR_AUTO:    rom_type <= ioctl_dout[15:8];
						HDR_HIROM:   rom_type <= MAP_HIROM;
						HDR_EXHIROM: rom_type <= MAP_EXHIROM;
						default:     rom_type <= MAP_LOROM;
					endcase
				end

				if (ioctl_addr == ioctl_addr_t'(2))
					rom_region <= ioctl_dout[8];

				if (hdr_forced) begin
					if (ioctl_addr == rom_size_addr)
						rom_size <= ioctl_dout[11:8];
					if (ioctl_addr == ram_size_addr)
						ram_size <= ioctl_dout[3:0];
				end
			end
		end else begin
			// Region only moves once the image is in
			case (region_sel)
				REGION_AUTO: pal <= rom_region;
				REGION_NTSC: pal <= 1'b0;
				REGION_PAL:  pal <= 1'b1;
				default:     pal <= 1'b0;
			endcase
		end
	end

	// Masks trail the size codes by one cycle
	always_ff @(posedge clk_sys) begin
		rom_mask <= (MASK_UNIT << rom_size) - mask_t'(1);
		ram_mask <= (ram_size != '0) ? (MASK_UNIT << ram_size) - mask_t'(1) : '0;
	end

endmodule

`default_nettype wire

/* cheat_assembler.sv */
// Builds 128-bit cheat codes from the eight words of a cheat record and flags each complete one
`timescale 1ns/1ns
`default_nettype none

module cheat_assembler
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        code_download,
	input  ioctl_addr_t ioctl_addr,
	input  word_t       ioctl_dout,
	input  logic        ioctl_wr,
	output cheat_code_t cheat_code,
	output logic        cheat_valid
);

	logic code_wr;

	assign code_wr = code_download && ioctl_wr;

	// Record slots, low word first within each field
	always_ff @(posedge clk_sys) begin
		if (code_wr) begin
			case (ioctl_addr[3:0])
				4'd0:  cheat_code.flags[15:0]    <= ioctl_dout;
				4'd2:  cheat_code.flags[31:16]   <= ioctl_dout;
				4'd4:  cheat_code.addr[15:0]     <= ioctl_dout;
				4'd6:  cheat_code.addr[31:16]    <= ioctl_dout;
				4'd8:  cheat_code.compare[15:0]  <= ioctl_dout;
				4'd10: cheat_code.compare[31:16] <= ioctl_dout;
				4'd12: cheat_code.replace[15:0]  <= ioctl_dout;
				4'd14: cheat_code.replace[31:16] <= ioctl_dout;
				default: ;
			endcase
		end
	end

	// Last word closes the record
	always_ff @(posedge clk_sys) begin
		if (reset)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= code_wr && ioctl_addr[3:0] == 4'd14;
	end

endmodule

`default_nettype wire

/* backup_ram.sv */
// Save RAM with a console byte port and a block-device word port; scrubbed during cartridge download
`timescale 1ns/1ns
`default_nettype none

module backup_ram
	import cart_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    cart_download,
	input  ioctl_addr_t             ioctl_addr,
	input  logic                    ioctl_wr,
	input  logic [BSRAM_BITS-1:0]   bsram_addr,
	input  byte_t                   bsram_d,
	input  logic                    bsram_we,
	input  sd_lba_t                 sd_lba,
	input  logic [SD_BUFF_BITS-1:0] sd_buff_addr,
	input  word_t                   sd_buff_dout,
	input  logic                    sd_buff_wr,
	input  logic                    sd_ack,
	output byte_t                   bsram_q,
	output word_t                   sd_buff_din
);

	// Word array, lane 0 holds the even byte
	logic [1:0][7:0] mem [2**BSRAM_WORD_BITS];

	logic [BSRAM_BITS-1:0]      a_addr;
	byte_t                      a_data;
	logic                       a_we;
	logic [BSRAM_WORD_BITS-1:0] b_addr;
	logic                       b_we;
	logic [1:0][7:0]            a_word;
	logic                       a_lane_q;

	// ====================================================================
	// Port A, console or scrub
	// ====================================================================
	assign a_addr = cart_download ? ioctl_addr[BSRAM_BITS-1:0] : bsram_addr;
	assign a_data = cart_download ? ioctl_addr[7:0] : bsram_d;
	assign a_we   = cart_download ? ioctl_wr : bsram_we;

	// ====================================================================
	// Port B, block device
	// ====================================================================
	assign b_addr = {sd_lba[BLOCK_SEL_BITS-1:0], sd_buff_addr};
	assign b_we   = sd_buff_wr && sd_ack;

	always_ff @(posedge clk_sys) begin
		if (a_we)
			mem[a_addr[BSRAM_BITS-1:1]][a_addr[0]] <= a_data;
		if (b_we)
			mem[b_addr] <= sd_buff_dout;
		a_word      <= mem[a_addr[BSRAM_BITS-1:1]];
		a_lane_q    <= a_addr[0];
		sd_buff_din <= mem[b_addr];
	end

	// Byte select after the read register
	assign bsram_q = a_word[a_lane_q];

endmodule

`default_nettype wire

/* loader_control.sv */
// Download decode, console reset, save enable tracking and the save RAM block transfer sequencer
`timescale 1ns/1ns
`default_nettype none

module loader_control
	import cart_pkg::*;
(
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        ioctl_download,
	input  logic [7:0]  ioctl_index,
	input  ioctl_addr_t ioctl_addr,
	input  logic        ioctl_wr,
	input  mask_t       ram_mask,
	input  logic        img_mounted,
	input  logic        img_readonly,
	input  logic [63:0] img_size,
	input  logic        sd_ack,
	input  logic        bsram_we,
	input  logic        bk_load,
	input  logic        bk_save,
	input  logic        autosave,
	input  logic        osd_status,
	output logic        cart_download,
	output logic        code_download,
	output logic        cheat_reset,
	output logic        console_reset,
	output sd_lba_t     sd_lba,
	output logic        sd_rd,
	output logic        sd_wr,
	output logic        bk_busy,
	output logic        bk_pending
);

	typedef enum logic {
		BK_IDLE,
		BK_XFER
	} bk_state_t;

	bk_state_t bk_state;
	logic      code_index;
	logic      old_download;
	logic      dl_start;
	logic      dl_end;
	logic      bk_ena;
	logic      bk_loading;
	logic      save_req;
	logic      old_load;
	logic      old_save;
	logic      old_ack;
	logic      load_edge;
	logic      save_edge;
	logic      ack_rise;
	logic      ack_fall;
	logic      start_load;
	logic      last_block;

	// ====================================================================
	// Download decode
	// ====================================================================
	assign code_index    = ioctl_index == CODE_INDEX;
	assign code_download = ioctl_download && code_index;
	assign cart_download = ioctl_download && !code_index;

	// New cartridge, or first word of a fresh cheat list
	assign cheat_reset   = cart_download || (code_download && ioctl_wr && ioctl_addr == '0);

	// Console held while the image or its save data comes in
	assign console_reset = reset || cart_download || bk_loading;

	assign dl_start = cart_download && !old_download;
	assign dl_end   = old_download && !cart_download && img_size != '0 && bk_ena;

	// ====================================================================
	// Save enable and dirty tracking
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			bk_ena       <= 1'b0;
		end else begin
			old_download <= cart_download;
			if (dl_start)
				bk_ena <= 1'b0;
			// Save image is mounted by the end of the download
			if (cart_download && img_mounted && !img_readonly)
				bk_ena <= ram_mask != '0;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset)
			bk_pending <= 1'b0;
		else if (bk_ena && !osd_status && bsram_we)
			bk_pending <= 1'b1;
		else if (bk_busy)
			bk_pending <= 1'b0;
	end

	// Autosave fires when the menu opens with unsaved writes
	assign save_req = bk_save || (autosave && bk_pending && osd_status);

	// ====================================================================
	// Block sequencer
	// ====================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load <= 1'b0;
			old_save <= 1'b0;
			old_ack  <= 1'b0;
		end else begin
			old_load <= bk_load;
			old_save <= save_req;
			old_ack  <= sd_ack;
		end
	end

	assign load_edge  = bk_load && !old_load && bk_ena;
	assign save_edge  = save_req && !old_save && bk_ena;
	assign ack_rise   = sd_ack && !old_ack;
	assign ack_fall   = old_ack && !sd_ack;
	assign start_load = dl_end || load_edge;
	assign last_block = sd_lba >= sd_lba_t'(ram_mask[23:BLOCK_BYTE_BITS]);
	assign bk_busy    = bk_state == BK_XFER;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bk_state   <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_lba     <= '0;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
		end else begin
			// Request drops once the device takes it
			if (ack_rise) begin
				sd_rd <= 1'b0;
				sd_wr <= 1'b0;
			end

			case (bk_state)
				BK_IDLE: begin
					if (start_load || save_edge) begin
						bk_state   <= BK_XFER;
						bk_loading <= start_load;
						sd_lba     <= '0;
						sd_rd      <= start_load;
						sd_wr      <= !start_load;
					end
				end
				BK_XFER: begin
					if (ack_fall) begin
						if (last_block) begin
							bk_state   <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_lba <= sd_lba + sd_lba_t'(1);
							sd_rd  <= bk_loading;
							sd_wr  <= !bk_loading;
						end
					end
				end
				default: bk_state <= BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* cart_loader_top.sv */
// Cartridge loader top level; connects download control to header detection, cheats and save RAM
`timescale 1ns/1ns
`default_nettype none

module cart_loader_top
	import cart_pkg::*;
(
	input  logic                    clk_sys,
	input  logic                    reset,
	input  logic                    ioctl_download,
	input  logic [7:0]              ioctl_index,
	input  ioctl_addr_t             ioctl_addr,
	input  word_t                   ioctl_dout,
	input  logic                    ioctl_wr,
	input  header_mode_t            header_mode,
	input  region_sel_t             region_sel,
	input  logic                    img_mounted,
	input  logic                    img_readonly,
	input  logic [63:0]             img_size,
	input  logic                    sd_ack,
	input  logic [SD_BUFF_BITS-1:0] sd_buff_addr,
	input  word_t                   sd_buff_dout,
	input  logic                    sd_buff_wr,
	input  logic [BSRAM_BITS-1:0]   bsram_addr,
	input  byte_t                   bsram_d,
	input  logic                    bsram_we,
	input  logic                    bk_load,
	input  logic                    bk_save,
	input  logic                    autosave,
	input  logic                    osd_status,
	output rom_type_t               rom_type,
	output mask_t                   rom_mask,
	output mask_t                   ram_mask,
	output logic                    pal,
	output cheat_code_t             cheat_code,
	output logic                    cheat_valid,
	output logic                    cheat_reset,
	output sd_lba_t                 sd_lba,
	output logic                    sd_rd,
	output logic                    sd_wr,
	output word_t                   sd_buff_din,
	output byte_t                   bsram_q,
	output logic                    bk_busy,
	output logic                    bk_pending,
	output logic                    console_reset
);

	logic cart_download;
	logic code_download;

	loader_control u_control (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl_addr),
		.ioctl_wr       (ioctl_wr),
		.ram_mask       (ram_mask),
		.img_mounted    (img_mounted),
		.img_readonly   (img_readonly),
		.img_size       (img_size),
		.sd_ack         (sd_ack),
		.bsram_we       (bsram_we),
		.bk_load        (bk_load),
		.bk_save        (bk_save),
		.autosave       (autosave),
		.osd_status     (osd_status),
		.cart_download  (cart_download),
		.code_download  (code_download),
		.cheat_reset    (cheat_reset),
		.console_reset  (console_reset),
		.sd_lba         (sd_lba),
		.sd_rd          (sd_rd),
		.sd_wr          (sd_wr),
		.bk_busy        (bk_busy),
		.bk_pending     (bk_pending)
	);

	header_detect u_header (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ioctl_wr      (ioctl_wr),
		.header_mode   (header_mode),
		.region_sel    (region_sel),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask),
		.pal           (pal)
	);

	cheat_assembler u_cheat (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.code_download (code_download),
		.ioctl_addr    (ioctl_addr),
		.ioctl_dout    (ioctl_dout),
		.ioctl_wr      (ioctl_wr),
		.cheat_code    (cheat_code),
		.cheat_valid   (cheat_valid)
	);

	backup_ram u_bsram (
		.clk_sys       (clk_sys),
		.cart_download (cart_download),
		.ioctl_addr    (ioctl_addr),
		.ioctl_wr      (ioctl_wr),
		.bsram_addr    (bsram_addr),
		.bsram_d       (bsram_d),
		.bsram_we      (bsram_we),
		.sd_lba        (sd_lba),
		.sd_buff_addr  (sd_buff_addr),
		.sd_buff_dout  (sd_buff_dout),
		.sd_buff_wr    (sd_buff_wr),
		.sd_ack        (sd_ack),
		.bsram_q       (bsram_q),
		.sd_buff_din   (sd_buff_din)
	);

endmodule

`default_nettype wire

/* tb_checks.svh */
// Compare tasks and model helpers for the cartridge loader testbench, included inside its top module
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ======================================================================
// Compare tasks for each kind of result
// ======================================================================
task automatic check_rom_type(input rom_type_t got, input rom_type_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %02h, expected %02h", what, got, exp));
endtask

task automatic check_mask(input mask_t got, input mask_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %06h, expected %06h", what, got, exp));
endtask

task automatic check_bit(input logic got, input logic exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %b, expected %b", what, got, exp));
endtask

task automatic check_cheat(input cheat_code_t got, input cheat_code_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %032h, expected %032h", what, got, exp));
endtask

task automatic check_byte(input byte_t got, input byte_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %02h, expected %02h", what, got, exp));
endtask

task automatic check_lba(input sd_lba_t got, input sd_lba_t exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s: got %08h, expected %08h", what, got, exp));
endtask

// ======================================================================
// Model helpers
// ======================================================================
// 1 KB shifted by the size code minus one
function automatic mask_t rom_code_to_mask(input size_code_t code);
	logic [31:0] span;
	span = (32'd1024 << code) - 32'd1;
	return span[23:0];
endfunction

// No save RAM when the code is zero
function automatic mask_t ram_code_to_mask(input size_code_t code);
	if (code == 4'h0)
		return '0;
	return rom_code_to_mask(code);
endfunction

function automatic ioctl_addr_t header_offset(input header_mode_t mode);
	case (mode)
		HDR_HIROM:   return HIROM_HDR;
		HDR_EXHIROM: return EXHIROM_HDR;
		default:     return LOROM_HDR;
	endcase
endfunction

function automatic rom_type_t forced_type(input header_mode_t mode);
	case (mode)
		HDR_HIROM:   return 8'd1;
		HDR_EXHIROM: return 8'd2;
		default:     return 8'd0;
	endcase
endfunction

// Word 0 is the low half of flags and word 7 the high half of replace
function automatic cheat_code_t pack_cheat(input word_t [7:0] words);
	cheat_code_t code;
	code.flags   = {words[1], words[0]};
	code.addr    = {words[3], words[2]};
	code.compare = {words[5], words[4]};
	code.replace = {words[7], words[6]};
	return code;
endfunction

`endif

/* tb_cart_loader.sv */
// Testbench for the cartridge loader top level with a block-device model, compiled from the file list
`timescale 1ns/1ns
`default_nettype none

module tb_cart_loader
	import cart_pkg::*;
();

	localparam logic [31:0] LFSR_SEED = 32'h7a7f3b5d;
	localparam int RAM_BYTES        = 2**BSRAM_BITS;
	localparam int IMAGE_WORDS      = RAM_BYTES / 2;
	localparam int RAM_BLOCKS       = RAM_BYTES / 512;
	localparam int HEADER_CASES     = 10;
	localparam int CHEAT_RECORDS    = 6;
	localparam int SCRUB_READS      = 64;
	localparam int CONSOLE_WRITES   = 32;
	localparam int LOAD_READS       = 128;
	localparam int BLOCK_CYCLES_MAX = 300;
	// Two cycles per loader word and console access plus one save and one load of every block
	localparam int CYCLE_LIMIT = 2 * (IMAGE_WORDS + 2 + HEADER_CASES * 5 + CHEAT_RECORDS * 8)
		+ 2 * (SCRUB_READS + CONSOLE_WRITES + LOAD_READS)
		+ 2 * RAM_BLOCKS * BLOCK_CYCLES_MAX + 1000;

	logic                    clk_sys;
	logic                    reset;
	logic                    ioctl_download;
	logic [7:0]              ioctl_index;
	ioctl_addr_t             ioctl_addr;
	word_t                   ioctl_dout;
	logic                    ioctl_wr;
	header_mode_t            header_mode;
	region_sel_t             region_sel;
	logic                    img_mounted;
	logic                    img_readonly;
	logic [63:0]             img_size;
	logic                    sd_ack;
	logic [SD_BUFF_BITS-1:0] sd_buff_addr;
	word_t                   sd_buff_dout;
	logic                    sd_buff_wr;
	logic [BSRAM_BITS-1:0]   bsram_addr;
	byte_t                   bsram_d;
	logic                    bsram_we;
	logic                    bk_load;
	logic                    bk_save;
	logic                    autosave;
	logic                    osd_status;
	rom_type_t               rom_type;
	mask_t                   rom_mask;
	mask_t                   ram_mask;
	logic                    pal;
	cheat_code_t             cheat_code;
	logic                    cheat_valid;
	logic                    cheat_reset;
	sd_lba_t                 sd_lba;
	logic                    sd_rd;
	logic                    sd_wr;
	word_t                   sd_buff_din;
	byte_t                   bsram_q;
	logic                    bk_busy;
	logic                    bk_pending;
	logic                    console_reset;

	logic [31:0] lfsr_state = LFSR_SEED;
	int          cycle_count = 0;
	byte_t       ram_model [RAM_BYTES];
	logic        ram_known [RAM_BYTES];
	word_t       dev_img [IMAGE_WORDS];

	cart_loader_top DUT (.*);

	initial begin
		clk_sys = 1'b0;
		forever #5 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Failure reporting and random numbers
	// ======================================================================
	task automatic abort_run();
		$display("test failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("[ERROR] %0t ns: %s", $time, msg);
		abort_run();
	endtask

	`include "tb_checks.svh"

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d clock cycles", CYCLE_LIMIT);
			abort_run();
		end
	end

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			value = {value[30:0], lfsr_state[0]};
		end
		return value;
	endfunction

	// ======================================================================
	// Loader and console drivers
	// ======================================================================
	task automatic write_word(input ioctl_addr_t addr, input word_t data);
		@(negedge clk_sys);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr   = 1'b1;
		@(negedge clk_sys);
		ioctl_wr   = 1'b0;
	endtask

	task automatic read_byte(input logic [BSRAM_BITS-1:0] addr, output byte_t data);
		@(negedge clk_sys);
		bsram_addr = addr;
		@(negedge clk_sys);
		data = bsram_q;
	endtask

	task automatic write_console(input logic [BSRAM_BITS-1:0] addr, input byte_t data);
		@(negedge clk_sys);
		bsram_addr = addr;
		bsram_d    = data;
		bsram_we   = 1'b1;
		@(negedge clk_sys);
		bsram_we   = 1'b0;
		ram_model[addr] = data;
		ram_known[addr] = 1'b1;
	endtask

	// Auto header image where every word also scrubs its save RAM byte
	task automatic cart_image(input word_t hdr, input int words);
		ioctl_addr_t addr;
		@(negedge clk_sys);
		header_mode    = HDR_AUTO;
		ioctl_index    = 8'h00;
		ioctl_download = 1'b1;
		for (int i = 0; i < words; i++) begin
			addr = ioctl_addr_t'(2 * i);
			write_word(addr, (i == 0) ? hdr : word_t'(rand_bits(16)));
			ram_model[addr[BSRAM_BITS-1:0]] = addr[7:0];
			ram_known[addr[BSRAM_BITS-1:0]] = 1'b1;
		end
		@(negedge clk_sys);
		ioctl_download = 1'b0;
	endtask

	task automatic header_case(input header_mode_t mode, input logic zero_low);
		word_t       hdr;
		word_t       noise;
		size_code_t  rom_code;
		size_code_t  ram_code;
		size_code_t  exp_rom_code;
		size_code_t  exp_ram_code;
		region_sel_t sel;
		logic        pal_before;
		ioctl_addr_t size_addr;

		hdr = word_t'(rand_bits(16));
		if (zero_low)
			hdr[7:0] = 8'h00;
		else if (hdr[7:0] == 8'h00)
			hdr[0] = 1'b1;
		noise     = word_t'(rand_bits(16));
		rom_code  = size_code_t'(rand_bits(4));
		ram_code  = size_code_t'(rand_bits(4));
		sel       = region_sel_t'(rand_bits(8) % 3);
		size_addr = header_offset(mode) + COPIER_OFFSET;

		@(negedge clk_sys);
		header_mode    = mode;
		pal_before     = pal;
		ioctl_index    = 8'h00;
		ioctl_download = 1'b1;
		write_word('0, hdr);
		write_word(ioctl_addr_t'(2), noise);
		write_word(size_addr, {noise[15:12], rom_code, noise[7:0]});
		write_word(size_addr + ioctl_addr_t'(2), {noise[11:0], ram_code});
		// New region choice must wait for the download to end
		region_sel = sel;
		@(negedge clk_sys);
		check_bit(pal, pal_before, "pal during download");
		check_bit(cheat_reset, 1'b1, "cheat_reset during cartridge download");
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		check_bit(cheat_reset, 1'b0, "cheat_reset after cartridge download");

		if (mode == HDR_AUTO && hdr[7:0] != 8'h00) begin
			exp_rom_code = hdr[3:0];
			exp_ram_code = hdr[7:4];
		end else if (mode >= HDR_LOROM) begin
			exp_rom_code = rom_code;
			exp_ram_code = ram_code;
		end else begin
			exp_rom_code = 4'hC;
			exp_ram_code = 4'h0;
		end
		check_rom_type(rom_type, (mode == HDR_AUTO) ? hdr[15:8] : forced_type(mode), "rom_type");
		check_mask(rom_mask, rom_code_to_mask(exp_rom_code), "rom_mask");
		check_mask(ram_mask, ram_code_to_mask(exp_ram_code), "ram_mask");
		check_bit(pal, (sel == REGION_AUTO) ? noise[8] : (sel == REGION_PAL), "pal after download");
	endtask

	task automatic cheat_records(input int count);
		word_t [7:0] words;
		word_t       noise;
		@(negedge clk_sys);
		ioctl_index    = CODE_INDEX;
		ioctl_download = 1'b1;
		for (int r = 0; r < count; r++) begin
			for (int w = 0; w < 8; w++) begin
				noise    = word_t'(rand_bits(16));
				words[w] = noise;
				@(negedge clk_sys);
				ioctl_addr = ioctl_addr_t'(r * 16 + w * 2);
				ioctl_dout = noise;
				ioctl_wr   = 1'b1;
				// Only the first word of the list clears the old codes
				#1 check_bit(cheat_reset, r == 0 && w == 0, "cheat_reset on cheat word");
				@(negedge clk_sys);
				ioctl_wr   = 1'b0;
				check_bit(cheat_valid, w == 7, "cheat_valid after record word");
			end
			check_cheat(cheat_code, pack_cheat(words), "cheat_code");
		end
		@(negedge clk_sys);
		check_bit(cheat_valid, 1'b0, "cheat_valid after last record");
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
	endtask

	// ======================================================================
	// Block device model
	// ======================================================================
	initial begin : block_device
		sd_lba_t lba;
		logic    to_device;
		int      base;

		sd_ack       = 1'b0;
		sd_buff_addr = '0;
		sd_buff_dout = '0;
		sd_buff_wr   = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				lba       = sd_lba;
				to_device = sd_wr;
				base      = int'(lba[BLOCK_SEL_BITS-1:0]) << SD_BUFF_BITS;
				repeat (int'(rand_bits(3))) @(negedge clk_sys);
				sd_ack = 1'b1;
				for (int i = 0; i < 256; i++) begin
					sd_buff_addr = i[SD_BUFF_BITS-1:0];
					sd_buff_dout = dev_img[base + i];
					sd_buff_wr   = !to_device;
					@(negedge clk_sys);
					// Save data arrives one cycle after its address
					if (to_device)
						dev_img[base + i] = sd_buff_din;
				end
				sd_buff_wr = 1'b0;
				sd_ack     = 1'b0;
			end
		end
	end

	// ======================================================================
	// Test sequence
	// ======================================================================
	initial begin : stimulus
		word_t                 noise;
		word_t                 image_word;
		logic [BSRAM_BITS-1:0] addr;
		byte_t                 got;

		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = 8'h00;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_wr       = 1'b0;
		header_mode    = HDR_AUTO;
		region_sel     = REGION_AUTO;
		img_mounted    = 1'b0;
		img_readonly   = 1'b0;
		img_size       = '0;
		bsram_addr     = '0;
		bsram_d        = '0;
		bsram_we       = 1'b0;
		bk_load        = 1'b0;
		bk_save        = 1'b0;
		autosave       = 1'b0;
		osd_status     = 1'b0;
		for (int a = 0; a < RAM_BYTES; a++)
			ram_known[a] = 1'b0;
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_bit(sd_rd, 1'b0, "sd_rd after reset");
		check_bit(sd_wr, 1'b0, "sd_wr after reset");
		check_bit(bk_busy, 1'b0, "bk_busy after reset");
		check_bit(bk_pending, 1'b0, "bk_pending after reset");
		check_bit(cheat_valid, 1'b0, "cheat_valid after reset");

		// Header detection and region
		header_case(HDR_AUTO, 1'b0);
		header_case(HDR_AUTO, 1'b1);
		for (int m = 1; m <= 4; m++)
			header_case(header_mode_t'(m), 1'b0);
		for (int k = 0; k < HEADER_CASES - 6; k++)
			header_case(header_mode_t'(rand_bits(8) % 5), 1'b0);

		cheat_records(CHEAT_RECORDS);

		// Scrub, console writes and save of every block
		img_mounted = 1'b1;
		img_size    = '0;
		noise       = word_t'(rand_bits(16));
		cart_image({noise[15:8], 4'h3, noise[3:0]}, IMAGE_WORDS);
		repeat (2) @(negedge clk_sys);
		check_mask(ram_mask, ram_code_to_mask(4'h3), "save RAM mask");
		for (int i = 0; i < SCRUB_READS; i++) begin
			addr    = BSRAM_BITS'(rand_bits(BSRAM_BITS));
			addr[0] = 1'b0;
			read_byte(addr, got);
			check_byte(got, ram_model[addr], "scrub pattern");
		end
		check_bit(bk_pending, 1'b0, "bk_pending before console writes");
		for (int i = 0; i < CONSOLE_WRITES; i++)
			write_console(BSRAM_BITS'(rand_bits(BSRAM_BITS)), byte_t'(rand_bits(8)));
		check_bit(bk_pending, 1'b1, "bk_pending after console writes");
		bk_save = 1'b1;
		@(negedge clk_sys);
		bk_save = 1'b0;
		while (!bk_busy)
			@(negedge clk_sys);
		while (bk_busy)
			@(negedge clk_sys);
		check_bit(bk_pending, 1'b0, "bk_pending after save");
		check_lba(sd_lba, sd_lba_t'(RAM_BLOCKS - 1), "last block of save");
		for (int a = 0; a < RAM_BYTES; a++) begin
			if (ram_known[a]) begin
				image_word = dev_img[a / 2];
				check_byte(a[0] ? image_word[15:8] : image_word[7:0], ram_model[a],
					"saved image byte");
			end
		end

		// Auto load of a fresh save image after the download
		for (int k = 0; k < IMAGE_WORDS; k++)
			dev_img[k] = word_t'(rand_bits(16));
		img_size = 64'h2000;
		noise    = word_t'(rand_bits(16));
		cart_image({noise[15:8], 4'h3, noise[3:0]}, 2);
		@(negedge clk_sys);
		check_bit(bk_busy, 1'b1, "auto load started");
		while (bk_busy) begin
			check_bit(console_reset, 1'b1, "console_reset during load");
			@(negedge clk_sys);
		end
		check_bit(console_reset, 1'b0, "console_reset after load");
		check_lba(sd_lba, sd_lba_t'(RAM_BLOCKS - 1), "last block of load");
		for (int i = 0; i < LOAD_READS; i++) begin
			addr = BSRAM_BITS'(rand_bits(BSRAM_BITS));
			read_byte(addr, got);
			image_word = dev_img[addr[BSRAM_BITS-1:1]];
			check_byte(got, addr[0] ? image_word[15:8] : image_word[7:0], "loaded byte");
		end

		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
+incdir+.
cart_pkg.sv
header_detect.sv
cheat_assembler.sv
backup_ram.sv
loader_control.sv
cart_loader_top.sv
tb_cart_loader.sv
